// File: common/alu_uart_pkg.sv
package alu_uart_pkg;

   localparam int DATA_WIDTH = 16;
   localparam int BIT_CNT_W  = 4;

   typedef logic [DATA_WIDTH-1:0] data_t;
   typedef logic [7:0]            byte_t;
   typedef logic [15:0]           bit_period_t;   // Clock cycles per UART bit

   // Low nibble of a command byte
   typedef enum logic [3:0] {
      LOAD_A    = 4'h0,
      LOAD_B    = 4'h1,
      READ_RES  = 4'h2,
      READ_STAT = 4'h3,
      OP_ADD    = 4'h4,
      OP_SUB    = 4'h5,
      OP_MUL    = 4'h6,
      OP_DIV    = 4'h7
   } cmd_op_e;

   // Same order as the low two bits of OP_ADD..OP_DIV
   typedef enum logic [1:0] {
      ADD,
      SUB,
      MUL,
      DIV
   } alu_op_e;

   typedef enum logic [2:0] {
      RX_CALIB,
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

   typedef enum logic [1:0] {ALU_IDLE, ALU_RUN, ALU_DONE} alu_state_e;

endpackage

// File: common/alu_if.sv
interface alu_if;

   // Request side, from the command controller
   alu_uart_pkg::data_t   a;
   alu_uart_pkg::data_t   b;
   alu_uart_pkg::alu_op_e op;
   logic                  valid;

   // Response side, from the ALU
   logic                  ready;
   alu_uart_pkg::data_t   q;
   logic                  ovf;
   logic                  zero;
   logic                  done;   // One-cycle pulse with q and flags

   modport ctrl (
      output a, b, op, valid,
      input  ready, q, ovf, zero, done
   );

   modport alu (
      input  a, b, op, valid,
      output ready, q, ovf, zero, done
   );

endinterface

// File: uart/uart_rx_autobaud.sv
module uart_rx_autobaud (
   input  logic                      i_clk,
   input  logic                      i_nrst,
   input  logic                      i_rx,
   output alu_uart_pkg::byte_t       o_data,
   output logic                      o_valid,
   output alu_uart_pkg::bit_period_t o_bit_period
);

   logic [2:0]                         rx_sync;
   logic                               rx_s;
   alu_uart_pkg::rx_state_e            state;
   alu_uart_pkg::bit_period_t          cnt;
   alu_uart_pkg::bit_period_t          half_period;
   logic [alu_uart_pkg::BIT_CNT_W-1:0] bit_cnt;
   logic                               discard;   // Rest of the calibration frame

   assign rx_s        = rx_sync[2];
   assign half_period = o_bit_period >> 1;

   // Line idles high, so the synchronizer resets to 1
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 3'b111;
      end else begin
         rx_sync <= {rx_sync[1:0], i_rx};
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state        <= alu_uart_pkg::RX_CALIB;
         cnt          <= '0;
         bit_cnt      <= '0;
         discard      <= 1'b0;
         o_data       <= '0;
         o_valid      <= 1'b0;
         o_bit_period <= '0;
      end else begin
         o_valid <= 1'b0;
         case (state)
            alu_uart_pkg::RX_CALIB: begin
               if (!rx_s) begin
                  cnt <= cnt + 16'd1;   // Low time of the first start bit
               end else if (cnt != '0) begin
                  o_bit_period <= cnt;
                  cnt          <= (cnt >> 1) - 16'd1;
                  bit_cnt      <= '0;
                  discard      <= 1'b1;
                  state        <= alu_uart_pkg::RX_DATA;   // Now at start of bit 0
               end
            end
            alu_uart_pkg::RX_IDLE: begin
               if (!rx_s) begin
                  cnt   <= half_period - 16'd1;
                  state <= alu_uart_pkg::RX_START;
               end
            end
            alu_uart_pkg::RX_START: begin
               if (cnt != '0) begin
                  cnt <= cnt - 16'd1;
               end else if (!rx_s) begin
                  cnt     <= o_bit_period - 16'd1;
                  bit_cnt <= '0;
                  state   <= alu_uart_pkg::RX_DATA;
               end else begin
                  state <= alu_uart_pkg::RX_IDLE;   // Glitch, not a start bit
               end
            end
            alu_uart_pkg::RX_DATA: begin
               if (cnt != '0) begin
                  cnt <= cnt - 16'd1;
               end else begin
                  o_data  <= {rx_s, o_data[7:1]};   // LSB first
                  cnt     <= o_bit_period - 16'd1;
                  bit_cnt <= bit_cnt + 4'd1;
                  if (bit_cnt == 4'd7) begin
                     state <= alu_uart_pkg::RX_STOP;
                  end
               end
            end
            alu_uart_pkg::RX_STOP: begin
               if (cnt != '0) begin
                  cnt <= cnt - 16'd1;
               end else begin
                  o_valid <= ~discard;   // Middle of stop bit
                  discard <= 1'b0;
                  state   <= alu_uart_pkg::RX_IDLE;
               end
            end
            default: begin
               state <= alu_uart_pkg::RX_IDLE;
            end
         endcase
      end
   end

endmodule

// File: uart/uart_tx.sv
module uart_tx (
   input  logic                      i_clk,
   input  logic                      i_nrst,
   input  alu_uart_pkg::byte_t       i_data,
   input  logic                      i_valid,
   input  alu_uart_pkg::bit_period_t i_bit_period,
   output logic                      o_ready,
   output logic                      o_tx
);

   alu_uart_pkg::tx_state_e            state;
   alu_uart_pkg::bit_period_t          cnt;
   alu_uart_pkg::byte_t                shreg;
   logic [alu_uart_pkg::BIT_CNT_W-1:0] bit_cnt;

   assign o_ready = (state == alu_uart_pkg::TX_IDLE);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= alu_uart_pkg::TX_IDLE;
         cnt     <= '0;
         shreg   <= '0;
         bit_cnt <= '0;
         o_tx    <= 1'b1;
      end else begin
         if (state != alu_uart_pkg::TX_IDLE && cnt != '0) begin
            cnt <= cnt - 16'd1;
         end else begin
            case (state)
               alu_uart_pkg::TX_IDLE: begin
                  if (i_valid) begin
                     shreg <= i_data;
                     o_tx  <= 1'b0;   // Start bit
                     cnt   <= i_bit_period - 16'd1;
                     state <= alu_uart_pkg::TX_START;
                  end
               end
               alu_uart_pkg::TX_START: begin
                  o_tx    <= shreg[0];
                  shreg   <= {1'b0, shreg[7:1]};
                  bit_cnt <= '0;
                  cnt     <= i_bit_period - 16'd1;
                  state   <= alu_uart_pkg::TX_DATA;
               end
               alu_uart_pkg::TX_DATA: begin
                  cnt <= i_bit_period - 16'd1;
                  if (bit_cnt == 4'd7) begin
                     o_tx  <= 1'b1;   // Stop bit
                     state <= alu_uart_pkg::TX_STOP;
                  end else begin
                     o_tx    <= shreg[0];
                     shreg   <= {1'b0, shreg[7:1]};
                     bit_cnt <= bit_cnt + 4'd1;
                  end
               end
               default: begin
                  state <= alu_uart_pkg::TX_IDLE;   // End of stop bit
               end
            endcase
         end
      end
   end

endmodule

// File: alu/seq_alu.sv
module seq_alu (
   input  logic i_clk,
   input  logic i_nrst,
   alu_if.alu   bus
);

   alu_uart_pkg::alu_state_e           state;
   alu_uart_pkg::alu_op_e              op_r;
   alu_uart_pkg::data_t                opnd;       // Multiplicand or divisor
   logic [2*alu_uart_pkg::DATA_WIDTH-1:0] prod;    // Product, or remainder and quotient
   logic [2*alu_uart_pkg::DATA_WIDTH-1:0] step_prod;
   logic [alu_uart_pkg::BIT_CNT_W-1:0] step_cnt;
   logic                               ovf_r;

   logic [alu_uart_pkg::DATA_WIDTH:0]  add_sum;
   logic [alu_uart_pkg::DATA_WIDTH:0]  sub_diff;
   logic [alu_uart_pkg::DATA_WIDTH:0]  mul_sum;
   logic [alu_uart_pkg::DATA_WIDTH:0]  div_shift;
   logic [alu_uart_pkg::DATA_WIDTH:0]  div_rem;
   logic                               div_ge;

   assign bus.ready = (state == alu_uart_pkg::ALU_IDLE);
   assign bus.done  = (state == alu_uart_pkg::ALU_DONE);
   assign bus.q     = prod[alu_uart_pkg::DATA_WIDTH-1:0];
   assign bus.ovf   = ovf_r;
   assign bus.zero  = (prod[alu_uart_pkg::DATA_WIDTH-1:0] == '0);

   // Single-cycle paths straight from the bus
   assign add_sum  = {1'b0, bus.a} + {1'b0, bus.b};
   assign sub_diff = {1'b0, bus.a} - {1'b0, bus.b};   // MSB is the borrow

   always_comb begin
      mul_sum   = {1'b0, prod[31:16]} + (prod[0] ? {1'b0, opnd} : 17'd0);
      div_shift = {prod[31:16], prod[15]};
      div_ge    = (div_shift >= {1'b0, opnd});
      div_rem   = div_shift - {1'b0, opnd};
      if (op_r == alu_uart_pkg::MUL) begin
         step_prod = {mul_sum, prod[15:1]};   // Shift-add step
      end else begin
         step_prod = {(div_ge ? div_rem[15:0] : div_shift[15:0]), prod[14:0], div_ge};
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= alu_uart_pkg::ALU_IDLE;
         op_r     <= alu_uart_pkg::ADD;
         opnd     <= '0;
         prod     <= '0;
         step_cnt <= '0;
         ovf_r    <= 1'b0;
      end else begin
         case (state)
            alu_uart_pkg::ALU_IDLE: begin
               if (bus.valid) begin
                  op_r     <= bus.op;
                  step_cnt <= '0;
                  case (bus.op)
                     alu_uart_pkg::ADD: begin
                        prod  <= {16'd0, add_sum[15:0]};
                        ovf_r <= add_sum[16];   // Carry out
                        state <= alu_uart_pkg::ALU_DONE;
                     end
                     alu_uart_pkg::SUB: begin
                        prod  <= {16'd0, sub_diff[15:0]};
                        ovf_r <= sub_diff[16];
                        state <= alu_uart_pkg::ALU_DONE;
                     end
                     alu_uart_pkg::MUL: begin
                        opnd  <= bus.a;
                        prod  <= {16'd0, bus.b};
                        state <= alu_uart_pkg::ALU_RUN;
                     end
                     default: begin
                        opnd  <= bus.b;
                        prod  <= {16'd0, bus.a};   // Dividend shifts out of the low half
                        state <= alu_uart_pkg::ALU_RUN;
                     end
                  endcase
               end
            end
            alu_uart_pkg::ALU_RUN: begin
               prod     <= step_prod;
               step_cnt <= step_cnt + 4'd1;
               if (step_cnt == 4'd15) begin
                  // Divide by zero yields all ones from the restoring steps
                  if (op_r == alu_uart_pkg::MUL) begin
                     ovf_r <= |step_prod[31:16];
                  end else begin
                     ovf_r <= (opnd == '0);
                  end
                  state <= alu_uart_pkg::ALU_DONE;
               end
            end
            default: begin
               state <= alu_uart_pkg::ALU_IDLE;
            end
         endcase
      end
   end

endmodule

// File: hdl/alu_cmd_ctrl.sv
module alu_cmd_ctrl (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  alu_uart_pkg::byte_t i_rx_data,
   input  logic                i_rx_valid,
   input  logic                i_tx_ready,
   output alu_uart_pkg::byte_t o_tx_data,
   output logic                o_tx_valid,
   alu_if.ctrl                 alu
);

   alu_uart_pkg::data_t   a_reg;
   alu_uart_pkg::data_t   b_reg;
   alu_uart_pkg::data_t   res_reg;
   alu_uart_pkg::byte_t   stat_reg;
   alu_uart_pkg::cmd_op_e cmd;
   logic [3:0]            nibble;

   assign cmd    = alu_uart_pkg::cmd_op_e'(i_rx_data[3:0]);
   assign nibble = i_rx_data[7:4];
   assign alu.a  = a_reg;
   assign alu.b  = b_reg;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         a_reg      <= '0;
         b_reg      <= '0;
         res_reg    <= '0;
         stat_reg   <= 8'h01;   // Result is zero after reset
         o_tx_data  <= '0;
         o_tx_valid <= 1'b0;
         alu.op     <= alu_uart_pkg::ADD;
         alu.valid  <= 1'b0;
      end else begin
         if (o_tx_valid && i_tx_ready) begin
            o_tx_valid <= 1'b0;
         end
         if (alu.valid && alu.ready) begin
            alu.valid <= 1'b0;
         end

         // Dropped while a reply is still waiting for the transmitter
         if (i_rx_valid && !o_tx_valid) begin
            case (cmd)
               alu_uart_pkg::LOAD_A: a_reg <= {a_reg[alu_uart_pkg::DATA_WIDTH-5:0], nibble};
               alu_uart_pkg::LOAD_B: b_reg <= {b_reg[alu_uart_pkg::DATA_WIDTH-5:0], nibble};
               alu_uart_pkg::READ_RES: begin
                  o_tx_data  <= res_reg[7:0];   // Low byte first
                  res_reg    <= res_reg >> 8;
                  o_tx_valid <= 1'b1;
               end
               alu_uart_pkg::READ_STAT: begin
                  o_tx_data  <= stat_reg;
                  o_tx_valid <= 1'b1;
               end
               alu_uart_pkg::OP_ADD, alu_uart_pkg::OP_SUB,
               alu_uart_pkg::OP_MUL, alu_uart_pkg::OP_DIV: begin
                  if (alu.ready && !alu.valid) begin
                     alu.op    <= alu_uart_pkg::alu_op_e'(i_rx_data[1:0]);
                     alu.valid <= 1'b1;
                  end
               end
               default: ;
            endcase
         end

         if (alu.done) begin
            res_reg  <= alu.q;
            stat_reg <= {6'd0, alu.ovf, alu.zero};
         end
      end
   end

endmodule

// File: hdl/alu_uart_top.sv
module alu_uart_top (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_rx,
   output logic o_tx
);

   alu_uart_pkg::byte_t       rx_data;
   logic                      rx_valid;
   alu_uart_pkg::bit_period_t bit_period;
   alu_uart_pkg::byte_t       tx_data;
   logic                      tx_valid;
   logic                      tx_ready;

   alu_if alu_bus ();

   uart_rx_autobaud u_rx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx         (i_rx),
      .o_data       (rx_data),
      .o_valid      (rx_valid),
      .o_bit_period (bit_period)
   );

   uart_tx u_tx (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_data       (tx_data),
      .i_valid      (tx_valid),
      .i_bit_period (bit_period),   // Learned by the receiver
      .o_ready      (tx_ready),
      .o_tx         (o_tx)
   );

   alu_cmd_ctrl u_ctrl (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_rx_data    (rx_data),
      .i_rx_valid   (rx_valid),
      .i_tx_ready   (tx_ready),
      .o_tx_data    (tx_data),
      .o_tx_valid   (tx_valid),
      .alu          (alu_bus.ctrl)
   );

   seq_alu u_alu (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .bus          (alu_bus.alu)
   );

endmodule

// File: sim/tb_alu_uart.sv
module tb_alu_uart;

   localparam int BIT_CYCLES     = 16;
   localparam int FRAME_CYCLES   = 10 * BIT_CYCLES;
   localparam int TEST_FRAMES    = 140;   // 9 op tests of about 15 frames, plus calibration
   localparam int TIMEOUT_CYCLES = TEST_FRAMES * FRAME_CYCLES * 3 / 2;
   localparam int REPLY_WAIT     = 24 * BIT_CYCLES;

   logic                i_clk;
   logic                i_nrst;
   logic                i_rx;
   logic                o_tx;

   logic [31:0]         lfsr;
   alu_uart_pkg::byte_t reply_byte;
   logic                reply_ok;
   logic                tx_idle_ok;
   int                  test_errs;
   int                  total_errs;
   int                  pass_cnt;
   int                  fail_cnt;
   int                  cycle_cnt;

   alu_uart_top u_alu_uart_top (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_rx   (i_rx),
      .o_tx   (o_tx)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task next_rand(input int nbits, output alu_uart_pkg::data_t v);
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[14:0], lfsr[0]};
      end
   endtask

   // Expected {ovf, result} from the arithmetic rules
   function automatic logic [16:0] model_op(input alu_uart_pkg::cmd_op_e op,
                                            input alu_uart_pkg::data_t a,
                                            input alu_uart_pkg::data_t b);
      logic [31:0]         full;
      alu_uart_pkg::data_t r;
      logic                ovf;
      case (op)
         alu_uart_pkg::OP_ADD: begin
            full = 32'(a) + 32'(b);
            r    = full[15:0];
            ovf  = (full > 32'h0000_ffff);   // Carry
         end
         alu_uart_pkg::OP_SUB: begin
            r   = a - b;
            ovf = (a < b);   // Borrow
         end
         alu_uart_pkg::OP_MUL: begin
            full = 32'(a) * 32'(b);
            r    = full[15:0];
            ovf  = (full >= 32'h0001_0000);
         end
         default: begin
            if (b == 16'd0) begin
               r   = 16'hffff;
               ovf = 1'b1;
            end else begin
               r   = a / b;
               ovf = 1'b0;
            end
         end
      endcase
      return {ovf, r};
   endfunction

   task send_byte(input alu_uart_pkg::byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};   // Stop, data LSB first, start
      @(posedge i_clk);
      for (int i = 0; i < 10; i++) begin
         i_rx <= frame[i];
         repeat (BIT_CYCLES) @(posedge i_clk);
      end
   endtask

   task send_cmd(input alu_uart_pkg::cmd_op_e op, input logic [3:0] nib);
      send_byte({nib, op});
   endtask

   task load_word(input alu_uart_pkg::cmd_op_e op, input alu_uart_pkg::data_t w);
      for (int i = 3; i >= 0; i--) begin
         send_cmd(op, w[4*i +: 4]);   // Oldest nibble ends up on top
      end
   endtask

   task watch_idle(input int ncycles);
      tx_idle_ok = 1'b1;
      repeat (ncycles) begin
         @(negedge i_clk);
         if (o_tx !== 1'b1) tx_idle_ok = 1'b0;
      end
   endtask

   task receive_reply();
      int n;
      n          = 0;
      reply_ok   = 1'b0;
      reply_byte = '0;
      while (o_tx !== 1'b0 && n < REPLY_WAIT) begin
         @(negedge i_clk);
         n++;
      end
      if (n < REPLY_WAIT) begin
         repeat (BIT_CYCLES / 2) @(negedge i_clk);   // Middle of start bit
         reply_ok = (o_tx === 1'b0);
         for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge i_clk);
            reply_byte[i] = o_tx;
         end
         repeat (BIT_CYCLES) @(negedge i_clk);
         reply_ok = reply_ok && (o_tx === 1'b1);
      end
   endtask

   task read_reply(input alu_uart_pkg::cmd_op_e op);
      fork
         send_cmd(op, 4'h0);
         receive_reply();
      join
      assert (reply_ok) else begin
         $display("no valid reply frame came back for command %h", op);
         test_errs++;
      end
   endtask

   task check_byte(input string what, input alu_uart_pkg::byte_t got,
                   input alu_uart_pkg::byte_t exp);
      assert (got === exp) else begin
         $display("MISMATCH %s: expected %h, got %h", what, exp, got);
         test_errs++;
      end
   endtask

   task finish_test(input string name);
      if (test_errs == 0) pass_cnt++;
      else fail_cnt++;
      $display("%-16s %s (%0d errors)", name, (test_errs == 0) ? "passed" : "failed", test_errs);
      total_errs += test_errs;
      test_errs   = 0;
   endtask

   task run_op(input string name, input alu_uart_pkg::cmd_op_e op,
               input alu_uart_pkg::data_t a, input alu_uart_pkg::data_t b);
      logic [16:0] exp;
      exp = model_op(op, a, b);
      load_word(alu_uart_pkg::LOAD_A, a);
      load_word(alu_uart_pkg::LOAD_B, b);
      send_cmd(op, 4'h0);
      read_reply(alu_uart_pkg::READ_RES);
      if (reply_ok) check_byte("o_tx result[7:0]", reply_byte, exp[7:0]);
      read_reply(alu_uart_pkg::READ_RES);
      if (reply_ok) check_byte("o_tx result[15:8]", reply_byte, exp[15:8]);
      read_reply(alu_uart_pkg::READ_STAT);
      if (reply_ok) check_byte("o_tx status", reply_byte, {6'd0, exp[16], exp[15:0] == 16'd0});
      finish_test(name);
   endtask

   initial begin
      alu_uart_pkg::data_t a;
      alu_uart_pkg::data_t b;
      i_rx       <= 1'b1;
      i_nrst     <= 1'b0;
      lfsr       = 32'h97d5_8dc6;
      test_errs  = 0;
      total_errs = 0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      repeat (16) @(posedge i_clk);
      i_nrst <= 1'b1;
      repeat (4) @(posedge i_clk);

      fork
         send_byte(8'h55);   // Calibration frame, bit 0 set
         watch_idle(12 * BIT_CYCLES);
      join
      assert (tx_idle_ok) else begin
         $display("o_tx left the idle level during calibration");
         test_errs++;
      end
      read_reply(alu_uart_pkg::READ_STAT);
      if (reply_ok) check_byte("o_tx status", reply_byte, 8'h01);
      finish_test("reset_status");

      next_rand(16, a);
      next_rand(16, b);
      run_op("add_random", alu_uart_pkg::OP_ADD, a, b);
      next_rand(16, a);
      if (a == 16'd0) a = 16'd1;
      run_op("add_carry_zero", alu_uart_pkg::OP_ADD, a, 16'h0 - a);   // Sum is 16'h10000
      next_rand(15, a);
      run_op("sub_borrow", alu_uart_pkg::OP_SUB, a, a | 16'h8000);
      next_rand(16, a);
      run_op("sub_equal", alu_uart_pkg::OP_SUB, a, a);
      next_rand(8, a);
      next_rand(8, b);
      run_op("mul_small", alu_uart_pkg::OP_MUL, a, b);
      next_rand(16, a);
      next_rand(16, b);
      run_op("mul_large", alu_uart_pkg::OP_MUL, a, b);
      next_rand(16, a);
      next_rand(8, b);
      run_op("div_random", alu_uart_pkg::OP_DIV, a, b);
      next_rand(16, a);
      run_op("div_zero", alu_uart_pkg::OP_DIV, a, 16'h0);
      next_rand(4, b);
      next_rand(16, a);
      send_cmd(alu_uart_pkg::LOAD_A, b[3:0]);   // Fifth nibble, pushed out by the next four
      run_op("nibble_shift", alu_uart_pkg::OP_ADD, a, 16'h0);

      $display("tests passed %0d, tests failed %0d, failed checks %0d",
               pass_cnt, fail_cnt, total_errs);
      if (total_errs == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: filelist.f
common/alu_uart_pkg.sv
common/alu_if.sv
uart/uart_rx_autobaud.sv
uart/uart_tx.sv
alu/seq_alu.sv
hdl/alu_cmd_ctrl.sv
hdl/alu_uart_top.sv
sim/tb_alu_uart.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_alu_uart -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q '^>>> FAIL$' sim.log; then
   exit 1
fi
exit 0
